//--- files.f
verilog/occupancy_pkg.sv
verilog/lane_if.sv
verilog/carry_sum_gen.sv
verilog/sample_splitter.sv
verilog/vc_occupancy_counter.sv
verilog/least_loaded_picker.sv
verilog/congestion_monitor.sv
sim/congestion_monitor_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP        := congestion_monitor_tb
RTL_TOP    := congestion_monitor
FILELIST   := files.f
OBJ_DIR    := obj_dir
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/congestion_monitor_tb.sv
module congestion_monitor_tb;

    localparam int NUM_PORTS     = occupancy_pkg::NUM_PORTS_DEF;
    localparam int VC_PER_PORT   = occupancy_pkg::VC_PER_PORT_DEF;
    localparam int TOTAL_W       = occupancy_pkg::TOTAL_W_DEF;
    localparam int BUS_W         = NUM_PORTS * VC_PER_PORT;
    localparam int CNT_W         = occupancy_pkg::count_width(VC_PER_PORT);
    localparam int PORT_W        = occupancy_pkg::port_width(NUM_PORTS);
    // largest value the total can show
    localparam int TOTAL_MAX     = (1 << TOTAL_W) - 1;
    localparam int NUM_DIRECTED  = 14;
    localparam int NUM_RANDOM    = 16;
    localparam int NUM_ROWS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int RESET_CYCLES  = 16;
    // edges from sample edge to visible result
    localparam int LATENCY       = 3;
    localparam int WATCHDOG_TIME = (NUM_ROWS + 16 + 20) * 100;

    localparam logic [VC_PER_PORT-1:0] FULL = '1;

    logic                 clk;
    logic                 rst;
    logic                 sample_valid;
    logic [BUS_W-1:0]     busy_bits;
    logic                 result_valid;
    logic [PORT_W-1:0]    least_port;
    logic [CNT_W-1:0]     least_count;
    logic [TOTAL_W-1:0]   total_busy;

    // stimulus rows and model results
    logic [BUS_W-1:0]     rows      [NUM_ROWS];
    logic [PORT_W-1:0]    exp_port  [NUM_ROWS];
    logic [CNT_W-1:0]     exp_count [NUM_ROWS];
    logic [TOTAL_W-1:0]   exp_total [NUM_ROWS];

    // rows in flight and the cycle each result is due
    int row_q [$];
    int due_q [$];

    int cycle = 0;
    int value_errors = 0;
    int protocol_errors = 0;

    // outputs seen at the last result for hold checks
    logic [PORT_W-1:0]    last_port;
    logic [CNT_W-1:0]     last_count;
    logic [TOTAL_W-1:0]   last_total;

    congestion_monitor dut0 (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .busy_bits    (busy_bits),
        .result_valid (result_valid),
        .least_port   (least_port),
        .least_count  (least_count),
        .total_busy   (total_busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // counts rising edges for the latency check
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // port 0 in the low bits
    function automatic logic [BUS_W-1:0] pack_ports(
        input logic [VC_PER_PORT-1:0] p0,
        input logic [VC_PER_PORT-1:0] p1,
        input logic [VC_PER_PORT-1:0] p2,
        input logic [VC_PER_PORT-1:0] p3
    );
        return {p3, p2, p1, p0};
    endfunction

    // reference model with per-port popcount, first minimum and clamped sum
    function automatic void model_row(
        input  logic [BUS_W-1:0]   bits,
        output logic [PORT_W-1:0]  port,
        output logic [CNT_W-1:0]   count,
        output logic [TOTAL_W-1:0] total
    );
        int n;
        int best_n;
        int best_p;
        int sum;
        best_n = VC_PER_PORT + 1;
        best_p = 0;
        sum    = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n = 0;
            for (int j = 0; j < VC_PER_PORT; j++) begin
                if (bits[p*VC_PER_PORT + j]) begin
                    n++;
                end
            end
            // strict less keeps the lower index on ties
            if (n < best_n) begin
                best_n = n;
                best_p = p;
            end
            sum += n;
        end
        port  = PORT_W'(best_p);
        count = CNT_W'(best_n);
        total = (sum > TOTAL_MAX) ? TOTAL_W'(TOTAL_MAX) : TOTAL_W'(sum);
    endfunction

    task automatic fill_table();
        logic [63:0] rnd;
        rows[0]  = '0;
        rows[1]  = '1;
        // one busy VC in the target port and two elsewhere
        rows[2]  = pack_ports(15'h0001, 15'h0003, 15'h0003, 15'h0003);
        rows[3]  = pack_ports(15'h0003, 15'h4000, 15'h0003, 15'h0003);
        rows[4]  = pack_ports(15'h0003, 15'h0003, 15'h0080, 15'h0003);
        rows[5]  = pack_ports(15'h0003, 15'h0003, 15'h0003, 15'h0100);
        // upper bits that need the second carry-sum block and bit 14
        rows[6]  = pack_ports(15'h7f80, FULL, FULL, FULL);
        rows[7]  = pack_ports(FULL, FULL, 15'h3f80, FULL);
        rows[8]  = pack_ports(FULL, 15'h5555, FULL, FULL);
        // all ports equal and then ports 1 and 3 tied
        rows[9]  = pack_ports(15'h0003, 15'h0300, 15'h0011, 15'h4001);
        rows[10] = pack_ports(15'h00ff, 15'h0007, 15'h001f, 15'h7000);
        rows[11] = pack_ports(FULL, FULL, FULL, 15'h2a00);
        // sum of 31 and then 32
        rows[12] = pack_ports(FULL, 15'h00ff, 15'h007f, 15'h0001);
        rows[13] = pack_ports(FULL, 15'h00ff, 15'h007f, 15'h0003);
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            rnd     = {$urandom(), $urandom()};
            rows[i] = rnd[BUS_W-1:0];
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            model_row(rows[i], exp_port[i], exp_count[i], exp_total[i]);
        end
    endtask

    // drives one sample just after the edge
    task automatic drive_row(input int idx);
        @(posedge clk);
        #5;
        sample_valid = 1'b1;
        busy_bits    = rows[idx];
        row_q.push_back(idx);
        due_q.push_back(cycle + LATENCY);
    endtask

    // no sample; bitmap toggles and must be ignored
    task automatic idle_cycle();
        @(posedge clk);
        #5;
        sample_valid = 1'b0;
        busy_bits    = ~busy_bits;
    endtask

    task automatic check_result();
        int idx;
        int due;
        if (row_q.size() == 0) begin
            $display("result_valid went high at time %0t with no sample waiting", $time);
            protocol_errors++;
        end else begin
            idx = row_q.pop_front();
            due = due_q.pop_front();
            if (due != cycle) begin
                $display("result for row %0d came at cycle %0d instead of cycle %0d",
                         idx, cycle, due);
                protocol_errors++;
            end
            if (least_port != exp_port[idx]) begin
                $display("error at %0t: row %0d least_port %0d, expected %0d",
                         $time, idx, least_port, exp_port[idx]);
                value_errors++;
            end
            if (least_count != exp_count[idx]) begin
                $display("error at %0t: row %0d least_count %0d, expected %0d",
                         $time, idx, least_count, exp_count[idx]);
                value_errors++;
            end
            if (total_busy != exp_total[idx]) begin
                $display("error at %0t: row %0d total_busy %0d, expected %0d",
                         $time, idx, total_busy, exp_total[idx]);
                value_errors++;
            end
        end
        last_port  = least_port;
        last_count = least_count;
        last_total = total_busy;
    endtask

    task automatic check_hold();
        if (least_port != last_port || least_count != last_count
                || total_busy != last_total) begin
            $display("error at %0t: outputs changed while result_valid was low", $time);
            value_errors++;
        end
        // oldest pending result overdue
        if (due_q.size() != 0 && due_q[0] < cycle) begin
            $display("no result arrived for row %0d by cycle %0d", row_q[0], due_q[0]);
            protocol_errors++;
            void'(row_q.pop_front());
            void'(due_q.pop_front());
        end
    endtask

    // monitor samples settled outputs on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (result_valid) begin
                check_result();
            end else begin
                check_hold();
            end
        end
    end

    initial begin
        void'($urandom(32'h7228));
        rst          = 1'b1;
        sample_valid = 1'b0;
        busy_bits    = '0;
        last_port    = '0;
        last_count   = '0;
        last_total   = '0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;
        // quiet cycles with no result expected
        repeat (3) idle_cycle();
        // directed rows as one back-to-back burst
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            drive_row(i);
        end
        idle_cycle();
        // random rows with a gap after every fourth
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            drive_row(i);
            if ((i - NUM_DIRECTED) % 4 == 3) begin
                idle_cycle();
            end
        end
        idle_cycle();
        while (row_q.size() != 0) begin
            @(negedge clk);
        end
        // catch stray strobes
        repeat (3) @(negedge clk);
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog/congestion_monitor.sv
module congestion_monitor #(
    parameter int NUM_PORTS   = occupancy_pkg::NUM_PORTS_DEF,
    parameter int VC_PER_PORT = occupancy_pkg::VC_PER_PORT_DEF,
    parameter int TOTAL_W     = occupancy_pkg::TOTAL_W_DEF
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               sample_valid,
    // port 0 in the low bits
    input  logic [NUM_PORTS*VC_PER_PORT-1:0]                   busy_bits,
    output logic                                               result_valid,
    output logic [occupancy_pkg::port_width(NUM_PORTS)-1:0]    least_port,
    output logic [occupancy_pkg::count_width(VC_PER_PORT)-1:0] least_count,
    output logic [TOTAL_W-1:0]                                 total_busy
);

    // one lane bundle per output port
    lane_if #(.VC_PER_PORT(VC_PER_PORT)) lanes [NUM_PORTS] ();

    // stage 1, capture and slice
    sample_splitter #(
        .NUM_PORTS   (NUM_PORTS),
        .VC_PER_PORT (VC_PER_PORT)
    ) u_splitter (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .busy_bits    (busy_bits),
        .lanes        (lanes)
    );

    // stage 2, per-port busy-VC counts
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
        vc_occupancy_counter #(
            .VC_PER_PORT (VC_PER_PORT)
        ) u_counter (
            .clk  (clk),
            .rst  (rst),
            .lane (lanes[i])
        );
    end

    // stage 3, least-loaded port and saturating total
    least_loaded_picker #(
        .NUM_PORTS   (NUM_PORTS),
        .VC_PER_PORT (VC_PER_PORT),
        .TOTAL_W     (TOTAL_W)
    ) u_picker (
        .clk          (clk),
        .rst          (rst),
        .lanes        (lanes),
        .result_valid (result_valid),
        .least_port   (least_port),
        .least_count  (least_count),
        .total_busy   (total_busy)
    );

endmodule

//--- verilog/least_loaded_picker.sv
module least_loaded_picker #(
    parameter int NUM_PORTS   = 4,
    parameter int VC_PER_PORT = 15,
    parameter int TOTAL_W     = 5
) (
    input  logic                                               clk,
    input  logic                                               rst,
    lane_if.picker                                             lanes [NUM_PORTS],
    output logic                                               result_valid,
    output logic [occupancy_pkg::port_width(NUM_PORTS)-1:0]    least_port,
    output logic [occupancy_pkg::count_width(VC_PER_PORT)-1:0] least_count,
    output logic [TOTAL_W-1:0]                                 total_busy
);

    localparam int CNT_W  = occupancy_pkg::count_width(VC_PER_PORT);
    localparam int PORT_W = occupancy_pkg::port_width(NUM_PORTS);
    // wide enough for every VC busy at once
    localparam int SUM_W  = occupancy_pkg::count_width(NUM_PORTS * VC_PER_PORT);

    logic [CNT_W-1:0]     counts [NUM_PORTS];
    logic [NUM_PORTS-1:0] valid_vec;
    logic                 valid_all;
    // one-hot winner
    logic [NUM_PORTS-1:0] min_vec;
    logic [PORT_W-1:0]    port_next;
    logic [CNT_W-1:0]     count_next;
    logic [SUM_W-1:0]     sum;
    logic [TOTAL_W-1:0]   total_next;

    occupancy_pkg::pick_state_e state;

    // unpack the lane array
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_unpack
        assign counts[i]    = lanes[i].count;
        assign valid_vec[i] = lanes[i].count_valid;
    end

    // lanes run in lockstep
    assign valid_all = &valid_vec;

    // fast minimum by pairwise compare
    if (NUM_PORTS == 1) begin : g_single
        assign min_vec = 1'b1;
    end else begin : g_cmp
        logic [NUM_PORTS-2:0] le_vec [NUM_PORTS];

        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_row
            for (genvar j = 0; j < NUM_PORTS - 1; j++) begin : g_col
                if (i > j) begin : g_mirror
                    // strict less against a lower index so ties go down
                    assign le_vec[i][j] = ~le_vec[j][i-1];
                end else begin : g_direct
                    assign le_vec[i][j] = (counts[i] <= counts[j+1]);
                end
            end
            assign min_vec[i] = &le_vec[i];
        end
    end

    // one-hot to binary and winner count by masking
    always_comb begin
        port_next  = '0;
        count_next = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            port_next  = port_next | ({PORT_W{min_vec[i]}} & PORT_W'(i));
            count_next = count_next | ({CNT_W{min_vec[i]}} & counts[i]);
        end
    end

    // total of all lanes
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            sum = sum + SUM_W'(counts[i]);
        end
    end

    // clamp to all ones on overflow
    if (SUM_W > TOTAL_W) begin : g_sat
        assign total_next = (|sum[SUM_W-1:TOTAL_W]) ? '1 : sum[TOTAL_W-1:0];
    end else begin : g_fit
        assign total_next = TOTAL_W'(sum);
    end

    // result stage holds its outputs between results
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= occupancy_pkg::PICK_IDLE;
            least_port  <= '0;
            least_count <= '0;
            total_busy  <= '0;
        end else begin
            state <= valid_all ? occupancy_pkg::PICK_VALID : occupancy_pkg::PICK_IDLE;
            if (valid_all) begin
                least_port  <= port_next;
                least_count <= count_next;
                total_busy  <= total_next;
            end
        end
    end

    assign result_valid = (state == occupancy_pkg::PICK_VALID);

    // exactly one winner on every valid count set
    a_min_onehot: assert property (
        @(posedge clk) disable iff (rst)
        valid_all |-> $onehot(min_vec)
    ) else $error("minimum vector not one-hot");

    // binary index and one-hot mux must name the same lane
    a_result_follows: assert property (
        @(posedge clk) disable iff (rst)
        valid_all |=> result_valid && (least_count == $past(counts[port_next]))
    ) else $error("result_valid or least_count out of step with the lanes");

endmodule

//--- verilog/vc_occupancy_counter.sv
module vc_occupancy_counter #(
    parameter int VC_PER_PORT = 15
) (
    input  logic clk,
    input  logic rst,
    lane_if.lane lane
);

    localparam int CNT_W = occupancy_pkg::count_width(VC_PER_PORT);

    // combinational busy-VC count of the current slice
    logic [CNT_W-1:0] count_next;

    if (VC_PER_PORT == 7) begin : g_pc7
        logic [2:0] abc;
        logic [1:0] carry_ones;

        // single carry-sum block whose carries weigh two
        carry_sum_gen u_cs (
            .in  (lane.bits),
            .abc (abc),
            .s   (count_next[0])
        );

        assign carry_ones = {1'b0, abc[0]} + {1'b0, abc[1]} + {1'b0, abc[2]};
        assign count_next[2:1] = carry_ones;

    end else if (VC_PER_PORT == 15) begin : g_pc15
        logic [2:0] abc0;
        logic [2:0] abc1;
        logic [2:0] abc_in;
        logic       s0;
        logic       s1;
        logic       s_in;
        // carry out of the three leftover weight-one bits
        logic       b2;
        logic [1:0] carry_ones;

        // first level over bits 6..0 and 13..7
        carry_sum_gen u_cs0 (
            .in  (lane.bits[6:0]),
            .abc (abc0),
            .s   (s0)
        );

        carry_sum_gen u_cs1 (
            .in  (lane.bits[13:7]),
            .abc (abc1),
            .s   (s1)
        );

        // bit 14 plus both sums gives the lsb of the result
        assign {b2, count_next[0]} = {1'b0, lane.bits[14]} + {1'b0, s0} + {1'b0, s1};

        // inner (7,3) stage over the seven weight-two bits
        carry_sum_gen u_cs_inner (
            .in  ({abc0, abc1, b2}),
            .abc (abc_in),
            .s   (s_in)
        );

        assign carry_ones = {1'b0, abc_in[0]} + {1'b0, abc_in[1]} + {1'b0, abc_in[2]};
        assign count_next[1]   = s_in;
        assign count_next[3:2] = carry_ones;

    end else begin : g_bad_width
        $error("vc_occupancy_counter supports 7 or 15 VCs per port");
    end

    // count stage one cycle behind the slice
    always_ff @(posedge clk) begin
        if (rst) begin
            lane.count_valid <= 1'b0;
            lane.count       <= '0;
        end else begin
            lane.count_valid <= lane.bits_valid;
            if (lane.bits_valid) begin
                lane.count <= count_next;
            end
        end
    end

    // carry-sum tree against a plain popcount of the counted slice
    a_count_match: assert property (
        @(posedge clk) disable iff (rst)
        lane.count_valid |-> (int'(lane.count) == $countones($past(lane.bits)))
    ) else $error("lane count differs from the busy VCs in its slice");

endmodule

//--- verilog/sample_splitter.sv
module sample_splitter #(
    parameter int NUM_PORTS   = 4,
    parameter int VC_PER_PORT = 15
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sample_valid,
    input  logic [NUM_PORTS*VC_PER_PORT-1:0] busy_bits,
    lane_if.splitter                         lanes [NUM_PORTS]
);

    // captured bitmap, port 0 in the low bits
    logic [NUM_PORTS*VC_PER_PORT-1:0] busy_q;
    logic                             valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            busy_q  <= '0;
        end else begin
            valid_q <= sample_valid;
            // hold last bitmap between samples
            if (sample_valid) begin
                busy_q <= busy_bits;
            end
        end
    end

    // fan the registered bitmap out, one slice per lane
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_slice
        assign lanes[i].bits_valid = valid_q;
        assign lanes[i].bits       = busy_q[i*VC_PER_PORT +: VC_PER_PORT];
    end

    // a sampled bitmap must be fully known
    a_known_sample: assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |-> !$isunknown(busy_bits)
    ) else $error("busy_bits has unknown bits while sample_valid is high");

endmodule

//--- verilog/carry_sum_gen.sv
module carry_sum_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    // low group of four, high group of three
    logic [3:0] grp_lo;
    logic [2:0] grp_hi;
    // ones in each group
    logic [2:0] ones_lo;
    logic [1:0] ones_hi;

    assign {grp_hi, grp_lo} = in;

    assign ones_lo = {2'b00, grp_lo[0]} + {2'b00, grp_lo[1]}
                   + {2'b00, grp_lo[2]} + {2'b00, grp_lo[3]};
    assign ones_hi = {1'b0, grp_hi[0]} + {1'b0, grp_hi[1]} + {1'b0, grp_hi[2]};

    // parity of the whole input
    assign s = ones_lo[0] ^ ones_hi[0];

    // a: two or more ones in the low group
    assign abc[2] = (ones_lo > 3'd1);
    // b: two or more ones in the high group
    assign abc[1] = (ones_hi > 2'd1);
    // c: four in the low group, or two odd groups that pair up
    assign abc[0] = (ones_lo == 3'd4) | (ones_lo[0] & ones_hi[0]);

endmodule

//--- verilog/lane_if.sv
interface lane_if #(
    parameter int VC_PER_PORT = 15
);

    localparam int CNT_W = occupancy_pkg::count_width(VC_PER_PORT);

    // one port's slice of the busy bitmap
    logic                   bits_valid;
    logic [VC_PER_PORT-1:0] bits;

    // busy-VC count of that slice, one stage later
    logic                   count_valid;
    logic [CNT_W-1:0]       count;

    modport splitter (output bits_valid, output bits);

    modport lane (
        input  bits_valid,
        input  bits,
        output count_valid,
        output count
    );

    modport picker (input count_valid, input count);

endinterface

//--- verilog/occupancy_pkg.sv
package occupancy_pkg;

    // default shape of the monitored router
    parameter int NUM_PORTS_DEF = 4;
    // only 7 or 15 VCs per port
    parameter int VC_PER_PORT_DEF = 15;
    // saturating total width, clamps at 31
    parameter int TOTAL_W_DEF = 5;

    // bits needed to hold a count of 0..vcs
    function automatic int count_width(input int vcs);
        return $clog2(vcs + 1);
    endfunction

    // index width for a port number, never zero
    function automatic int port_width(input int ports);
        if (ports > 1) begin
            return $clog2(ports);
        end
        return 1;
    endfunction

    // picker output state
    typedef enum logic {
        PICK_IDLE  = 1'b0,
        PICK_VALID = 1'b1
    } pick_state_e;

endpackage
